// ==== design/csr_defs.svh ====
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_ADDR_W   14
`define CSR_DATA_W   32
`define ECODE_W      6
`define ESUBCODE_W   9

// csr addresses
`define CSR_CRMD     14'h000
`define CSR_PRMD     14'h001
`define CSR_ECFG     14'h004
`define CSR_ESTAT    14'h005
`define CSR_ERA      14'h006
`define CSR_EENTRY   14'h00c
`define CSR_SAVE0    14'h030
`define CSR_SAVE1    14'h031
`define CSR_SAVE2    14'h032
`define CSR_SAVE3    14'h033
`define CSR_TID      14'h040
`define CSR_TCFG     14'h041
`define CSR_TVAL     14'h042
`define CSR_CNTC     14'h043
`define CSR_TICLR    14'h044

// exception causes that step the return pc
`define ECODE_INT    6'h00
`define ECODE_SYS    6'h0b
`define ECODE_BRK    6'h0c
`define ECODE_INE    6'h0d

`define CRMD_RST     32'h0000_0008  // direct address mode
`define TVAL_RST     32'hffff_ffff

// software writable bits per register
`define CRMD_WBITS   32'h0000_001f
`define PRMD_WBITS   32'h0000_0007
`define ECFG_WBITS   32'h0000_1bff  // bit 10 reserved
`define ESTAT_WBITS  32'h0000_0003  // sw pending only
`define EENTRY_WBITS 32'hffff_ffc0

`endif

// ==== design/csr_regs_pkg.sv ====
`include "csr_defs.svh"

package csr_regs_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    typedef struct packed {
        logic [26:0] rsvd;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    // local enables, one per interrupt line
    typedef struct packed {
        logic [18:0] rsvd;
        logic [12:0] lie;
    } ecfg_t;

    typedef struct packed {
        logic                   rsvd_31;
        logic [`ESUBCODE_W-1:0] esubcode;
        logic [`ECODE_W-1:0]    ecode;
        logic [3:0]             rsvd_12;
        logic                   is_timer;   // line 11
        logic                   rsvd_10;
        logic [7:0]             is_hw;
        logic [1:0]             is_sw;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;   // reload value, in units of 4
        logic        periodic;
        logic        en;
    } tcfg_t;

endpackage

// ==== design/csr_trap_pkg.sv ====
`include "csr_defs.svh"

package csr_trap_pkg;
    import csr_regs_pkg::*;

    typedef struct packed {
        logic      we;
        csr_addr_t waddr;
        csr_data_t wmask;
        csr_data_t wdata;
    } csr_wr_t;

    typedef struct packed {
        logic                   ex_en;
        logic                   ertn_flush;
        logic [`ECODE_W-1:0]    ecode;
        logic [`ESUBCODE_W-1:0] esubcode;
        csr_data_t              pc;
    } trap_evt_t;

    typedef struct packed {
        crmd_t                  crmd;
        prmd_t                  prmd;
        csr_data_t              era;
        csr_data_t              eentry;
        logic [`ECODE_W-1:0]    ecode;      // latched cause
        logic [`ESUBCODE_W-1:0] esubcode;
    } trap_state_t;

    // masked update limited to the writable bits
    function automatic csr_data_t wr_merge(csr_data_t old, csr_wr_t req, csr_data_t wbits);
        csr_data_t upd;
        upd = (req.wdata & req.wmask) | (old & ~req.wmask);
        return (upd & wbits) | (old & ~wbits);
    endfunction

endpackage

// ==== design/csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_trap_ctrl
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  csr_wr_t     wr,
    input  trap_evt_t   evt,
    output trap_state_t state,
    output csr_data_t   new_pc
);

    crmd_t                  crmd;
    prmd_t                  prmd;
    csr_data_t              era;
    csr_data_t              eentry;
    logic [`ECODE_W-1:0]    ecode;
    logic [`ESUBCODE_W-1:0] esubcode;
    logic                   in_ex;     // exception taken, no ertn yet
    logic                   step_cause;

    wire crmd_we   = wr.we && (wr.waddr == `CSR_CRMD);
    wire prmd_we   = wr.we && (wr.waddr == `CSR_PRMD);
    wire era_we    = wr.we && (wr.waddr == `CSR_ERA);
    wire eentry_we = wr.we && (wr.waddr == `CSR_EENTRY);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd <= crmd_t'(`CRMD_RST);
        end else if (evt.ex_en) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (evt.ertn_flush) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (crmd_we) begin
            crmd <= crmd_t'(wr_merge(crmd, wr, `CRMD_WBITS));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd <= '0;
        end else if (evt.ex_en) begin
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
        end else if (prmd_we) begin
            prmd <= prmd_t'(wr_merge(prmd, wr, `PRMD_WBITS));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era      <= '0;
            ecode    <= '0;
            esubcode <= '0;
            in_ex    <= 1'b0;
        end else if (evt.ex_en) begin
            era      <= evt.pc;
            ecode    <= evt.ecode;
            esubcode <= evt.esubcode;
            in_ex    <= 1'b1;
        end else begin
            if (era_we)
                era <= wr.wdata;    // mask not applied
            if (evt.ertn_flush)
                in_ex <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            eentry <= '0;
        else if (eentry_we)
            eentry <= wr_merge(eentry, wr, `EENTRY_WBITS);
    end

    assign step_cause = (ecode == `ECODE_INT) || (ecode == `ECODE_SYS) ||
                        (ecode == `ECODE_BRK) || (ecode == `ECODE_INE);

    // skip the trapping instruction
    assign new_pc = (in_ex && step_cause) ? era + 32'd4 : era;

    assign state = '{crmd: crmd, prmd: prmd, era: era, eentry: eentry,
                     ecode: ecode, esubcode: esubcode};

endmodule

// ==== design/csr_int_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_int_ctrl
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  csr_wr_t    wr,
    input  logic [7:0] hw_int,
    input  logic       timer_fire,
    input  logic       ie,
    output ecfg_t      ecfg,
    output estat_t     pend,
    output logic       has_int
);

    logic [1:0] is_sw;
    logic [7:0] is_hw;
    logic       is_timer;
    estat_t     sw_next;
    logic [12:0] int_vec;

    wire ecfg_we  = wr.we && (wr.waddr == `CSR_ECFG);
    wire estat_we = wr.we && (wr.waddr == `CSR_ESTAT);
    wire ticlr    = wr.we && (wr.waddr == `CSR_TICLR) && wr.wdata[0];

    assign sw_next = estat_t'(wr_merge(pend, wr, `ESTAT_WBITS));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg     <= '0;
            is_sw    <= '0;
            is_hw    <= '0;
            is_timer <= 1'b0;
        end else begin
            if (ecfg_we)
                ecfg <= ecfg_t'(wr_merge(ecfg, wr, `ECFG_WBITS));
            if (estat_we)
                is_sw <= sw_next.is_sw;
            is_hw <= hw_int;    // level sampled each cycle
            if (ticlr)
                is_timer <= 1'b0;
            else if (timer_fire)
                is_timer <= 1'b1;
        end
    end

    always_comb begin
        pend          = '0;
        pend.is_sw    = is_sw;
        pend.is_hw    = is_hw;
        pend.is_timer = is_timer;
    end

    assign int_vec = ecfg.lie & pend[12:0];
    assign has_int = ie && (|int_vec);

endmodule

// ==== design/csr_timer.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_timer
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  csr_wr_t     wr,
    output tcfg_t       tcfg,
    output csr_data_t   tval,
    output csr_data_t   cntc,
    output logic        timer_fire,
    output logic [63:0] counter
);

    logic        timer_en;
    logic [63:0] stable_cnt;

    wire tcfg_we = wr.we && (wr.waddr == `CSR_TCFG);
    wire tval_we = wr.we && (wr.waddr == `CSR_TVAL);
    wire cntc_we = wr.we && (wr.waddr == `CSR_CNTC);

    // a tcfg write overrides the expiry in the same cycle
    assign timer_fire = timer_en && (tval == '0) && !tcfg_we;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg     <= tcfg_t'(wr.wdata);
            timer_en <= wr.wdata[0];
        end else if (timer_fire) begin
            timer_en <= tcfg.periodic;  // one-shot stops here
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval <= `TVAL_RST;
        end else if (tcfg_we) begin
            tval <= {wr.wdata[31:2], 2'b00};
        end else if (tval_we) begin
            tval <= wr.wdata;
        end else if (timer_en) begin
            if (tval != '0)
                tval <= tval - 32'd1;
            else if (tcfg.periodic)
                tval <= {tcfg.initval, 2'b00};
            else
                tval <= `TVAL_RST;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            cntc <= '0;
        else if (cntc_we)
            cntc <= wr.wdata;
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            stable_cnt <= '0;
        else
            stable_cnt <= stable_cnt + 64'd1;
    end

    // signed offset applied on the way out
    assign counter = stable_cnt + {{32{cntc[31]}}, cntc};

endmodule

// ==== design/csr_save_regs.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_save_regs
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  csr_wr_t         wr,
    output csr_data_t [3:0] save,
    output csr_data_t       tid
);

    logic [3:0] save_we;

    wire tid_we = wr.we && (wr.waddr == `CSR_TID);

    // save0..3 sit on consecutive addresses
    for (genvar g = 0; g < 4; g++) begin : g_save_dec
        localparam csr_addr_t ADDR = csr_addr_t'(`CSR_SAVE0 + g);
        assign save_we[g] = wr.we && (wr.waddr == ADDR);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            save <= '0;
            tid  <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (save_we[i])
                    save[i] <= wr.wdata;
            end
            if (tid_we)
                tid <= wr.wdata;
        end
    end

endmodule

// ==== design/csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_read_mux
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input  csr_addr_t       raddr,
    input  trap_state_t     trap,
    input  ecfg_t           ecfg,
    input  estat_t          pend,
    input  tcfg_t           tcfg,
    input  csr_data_t       tval,
    input  csr_data_t       cntc,
    input  csr_data_t [3:0] save,
    input  csr_data_t       tid,
    output csr_data_t       rdata
);

    estat_t estat;

    // pending bits from int ctrl, cause from trap ctrl
    always_comb begin
        estat          = pend;
        estat.ecode    = trap.ecode;
        estat.esubcode = trap.esubcode;
    end

    always_comb begin
        case (raddr)
            `CSR_CRMD:   rdata = trap.crmd;
            `CSR_PRMD:   rdata = trap.prmd;
            `CSR_ECFG:   rdata = ecfg;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = trap.era;
            `CSR_EENTRY: rdata = trap.eentry;
            `CSR_SAVE0:  rdata = save[0];
            `CSR_SAVE1:  rdata = save[1];
            `CSR_SAVE2:  rdata = save[2];
            `CSR_SAVE3:  rdata = save[3];
            `CSR_TID:    rdata = tid;
            `CSR_TCFG:   rdata = tcfg;
            `CSR_TVAL:   rdata = tval;
            `CSR_CNTC:   rdata = cntc;
            `CSR_TICLR:  rdata = '0;     // write-only clear
            default:     rdata = '0;
        endcase
    end

endmodule

// ==== design/csr_top.sv ====
`timescale 1ns/1ps

module csr_top
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  csr_wr_t     wr,
    input  csr_addr_t   raddr,
    input  trap_evt_t   evt,
    input  logic [7:0]  hw_int,
    output csr_data_t   rdata,
    output logic        has_int,
    output csr_data_t   new_pc,
    output csr_data_t   ex_entry_pc,
    output logic [63:0] counter
);

    trap_state_t     trap_st;
    ecfg_t           ecfg;
    estat_t          pend;
    tcfg_t           tcfg;
    csr_data_t       tval;
    csr_data_t       cntc;
    csr_data_t [3:0] save;
    csr_data_t       tid;
    logic            timer_fire;

    csr_trap_ctrl u_trap_ctrl (
        .clk    (clk),
        .rstn   (rstn),
        .wr     (wr),
        .evt    (evt),
        .state  (trap_st),
        .new_pc (new_pc)
    );

    csr_int_ctrl u_int_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (wr),
        .hw_int     (hw_int),
        .timer_fire (timer_fire),
        .ie         (trap_st.crmd.ie),
        .ecfg       (ecfg),
        .pend       (pend),
        .has_int    (has_int)
    );

    csr_timer u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (wr),
        .tcfg       (tcfg),
        .tval       (tval),
        .cntc       (cntc),
        .timer_fire (timer_fire),
        .counter    (counter)
    );

    csr_save_regs u_save_regs (
        .clk  (clk),
        .rstn (rstn),
        .wr   (wr),
        .save (save),
        .tid  (tid)
    );

    csr_read_mux u_read_mux (
        .raddr (raddr),
        .trap  (trap_st),
        .ecfg  (ecfg),
        .pend  (pend),
        .tcfg  (tcfg),
        .tval  (tval),
        .cntc  (cntc),
        .save  (save),
        .tid   (tid),
        .rdata (rdata)
    );

    assign ex_entry_pc = trap_st.eentry;   // low six bits always zero

endmodule

// ==== verification/csr_tb_clkgen.sv ====
`timescale 1ns/1ps

module csr_tb_clkgen #(
    parameter int HALF_PERIOD = 4,
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;     // released just after the edge
    end

endmodule

// ==== verification/csr_checker.sv ====
`timescale 1ns/1ps

module csr_checker
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
(
    input logic      clk,
    input logic      rstn,
    input trap_evt_t evt,
    input crmd_t     crmd,
    input logic      in_ex
);

    int assert_errs = 0;

    // first cycle out of reset
    a_no_ex_after_rst: assert property (@(posedge clk) !rstn |=> !in_ex)
        else begin
            $error("exception flag set right after reset");
            assert_errs++;
        end

    a_ie_cleared: assert property (@(posedge clk) disable iff (!rstn)
        evt.ex_en |=> !crmd.ie)
        else begin
            $error("crmd.ie still set one cycle after exception entry");
            assert_errs++;
        end

    a_evt_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(evt.ex_en && evt.ertn_flush))
        else begin
            $error("ex_en and ertn_flush high in the same cycle");
            assert_errs++;
        end

    a_ertn_closes: assert property (@(posedge clk) disable iff (!rstn)
        evt.ertn_flush |=> !in_ex)
        else begin
            $error("exception still open one cycle after ertn");
            assert_errs++;
        end

endmodule

bind csr_trap_ctrl csr_checker u_checker (
    .clk   (clk),
    .rstn  (rstn),
    .evt   (evt),
    .crmd  (crmd),
    .in_ex (in_ex)
);

// ==== verification/csr_tb.sv ====
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_tb
    import csr_regs_pkg::*;
    import csr_trap_pkg::*;
();

    localparam int ONESHOT_INIT  = 5;
    localparam int PERIODIC_INIT = 4;
    localparam int INT_TIMEOUT   = 200;
    localparam int CNT_GAP       = 20;

    logic        clk;
    logic        rstn;
    csr_wr_t     wr;
    csr_addr_t   raddr;
    trap_evt_t   evt;
    logic [7:0]  hw_int;
    csr_data_t   rdata;
    logic        has_int;
    csr_data_t   new_pc;
    csr_data_t   ex_entry_pc;
    logic [63:0] counter;

    integer seed;
    int     err_cnt;
    int     pass_cnt;
    int     fail_cnt;

    csr_tb_clkgen u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    csr_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .wr          (wr),
        .raddr       (raddr),
        .evt         (evt),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .has_int     (has_int),
        .new_pc      (new_pc),
        .ex_entry_pc (ex_entry_pc),
        .counter     (counter)
    );

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_counter(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t mask, input csr_data_t data);
        wr = '{we: 1'b1, waddr: addr, wmask: mask, wdata: data};
        tick();
        wr.we = 1'b0;
    endtask

    // the read port is combinational so sample mid cycle
    task automatic read_csr(input csr_addr_t addr, output csr_data_t data);
        raddr = addr;
        @(negedge clk);
        data = rdata;
        tick();
    endtask

    task automatic pulse_evt(input logic ertn, input logic [5:0] ecode, input csr_data_t pc);
        evt = '{ex_en: !ertn, ertn_flush: ertn, ecode: ecode, esubcode: '0, pc: pc};
        tick();
        evt = '0;
    endtask

    task automatic expect_int(input string name, input logic level);
        @(negedge clk);
        check_bit(name, has_int, level);
        tick();
    endtask

    task automatic wait_int(input int max_cyc, output bit hit);
        hit = 1'b0;
        for (int i = 0; i < max_cyc && !hit; i++) begin
            @(negedge clk);
            hit = (has_int === 1'b1);
            tick();
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            $display("%s: ok", name);
            pass_cnt++;
        end else begin
            $display("%s: failed with %0d errors", name, err_cnt - err_before);
            fail_cnt++;
        end
    endtask

    function automatic csr_addr_t save_addr(input int idx);
        return (idx < 4) ? csr_addr_t'(`CSR_SAVE0 + idx) : `CSR_TID;
    endfunction

    task automatic test_reset_access();
        int        e0;
        csr_data_t vals [5];
        csr_data_t d;
        csr_data_t m;
        csr_data_t rd;
        e0 = err_cnt;
        read_csr(`CSR_CRMD, rd);
        check_data("crmd", rd, 32'h0000_0008);
        read_csr(`CSR_TVAL, rd);
        check_data("tval", rd, 32'hffff_ffff);
        for (int i = 0; i < 5; i++) begin
            vals[i] = $random(seed);
            write_csr(save_addr(i), '1, vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            read_csr(save_addr(i), rd);
            check_data("save/tid", rd, vals[i]);
        end
        d = $random(seed) | 32'hffff_e400;  // always offer the reserved bits
        m = $random(seed) | 32'hffff_e400;
        write_csr(`CSR_ECFG, m, d);
        read_csr(`CSR_ECFG, rd);
        check_data("ecfg", rd, d & m & 32'h0000_1bff);  // bit 10 and bits above 12 never stick
        write_csr(`CSR_ECFG, '1, '0);
        read_csr(`CSR_TICLR, rd);
        check_data("ticlr", rd, '0);
        finish_test("reset and masked access", e0);
    endtask

    task automatic test_trap();
        int        e0;
        csr_data_t pc;
        csr_data_t ent;
        csr_data_t rd;
        e0 = err_cnt;
        write_csr(`CSR_CRMD, 32'h7, 32'h7);   // plv 3, ie 1
        ent = $random(seed);
        write_csr(`CSR_EENTRY, '1, ent);
        pc = $random(seed);
        pulse_evt(1'b0, 6'h0b, pc);
        read_csr(`CSR_ERA, rd);
        check_data("era", rd, pc);
        read_csr(`CSR_CRMD, rd);
        check_data("crmd.plv_ie", rd & 32'h7, 32'h0);
        read_csr(`CSR_PRMD, rd);
        check_data("prmd.pplv_pie", rd & 32'h7, 32'h7);
        read_csr(`CSR_ESTAT, rd);
        check_data("estat.ecode", (rd >> 16) & 32'h3f, 32'h0b);
        @(negedge clk);
        check_data("new_pc", new_pc, pc + 32'd4);
        check_data("ex_entry_pc", ex_entry_pc, ent & 32'hffff_ffc0);
        tick();
        pulse_evt(1'b1, 6'h00, '0);
        read_csr(`CSR_CRMD, rd);
        check_data("crmd.plv_ie", rd & 32'h7, 32'h7);
        @(negedge clk);
        check_data("new_pc", new_pc, pc);
        tick();
        // cause that does not step the pc
        pc = $random(seed);
        pulse_evt(1'b0, 6'h07, pc);
        @(negedge clk);
        check_data("new_pc", new_pc, pc);
        tick();
        pulse_evt(1'b1, 6'h00, '0);
        finish_test("exception entry and return", e0);
    endtask

    task automatic test_interrupts();
        int        e0;
        csr_data_t rd;
        e0 = err_cnt;
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        write_csr(`CSR_ECFG, '1, 32'h1);
        write_csr(`CSR_ESTAT, 32'h3, 32'h1);
        expect_int("has_int sw", 1'b1);
        write_csr(`CSR_CRMD, 32'h4, 32'h0);
        expect_int("has_int sw, ie clear", 1'b0);
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        expect_int("has_int sw, ie set", 1'b1);
        write_csr(`CSR_ESTAT, 32'h3, 32'h0);
        expect_int("has_int sw cleared", 1'b0);
        hw_int = 8'h04;
        tick();
        read_csr(`CSR_ESTAT, rd);
        check_data("estat.is_hw", (rd >> 2) & 32'hff, 32'h04);
        expect_int("has_int hw disabled", 1'b0);
        write_csr(`CSR_ECFG, '1, 32'h10);   // line 4 is hw bit 2
        expect_int("has_int hw enabled", 1'b1);
        hw_int = 8'h00;
        tick();
        expect_int("has_int hw dropped", 1'b0);
        write_csr(`CSR_ECFG, '1, '0);
        finish_test("software and hardware interrupts", e0);
    endtask

    task automatic test_oneshot();
        int e0;
        bit hit;
        e0 = err_cnt;
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        write_csr(`CSR_ECFG, '1, 32'h800);  // timer line
        write_csr(`CSR_TCFG, '1, {30'(ONESHOT_INIT), 2'b01});
        wait_int(INT_TIMEOUT, hit);
        if (!hit) begin
            $display("timeout waiting for the one-shot timer interrupt");
            err_cnt++;
        end
        write_csr(`CSR_TICLR, '1, 32'h1);
        expect_int("has_int after ticlr", 1'b0);
        wait_int(2 * (4 * ONESHOT_INIT + 1), hit);
        if (hit) begin
            $display("one-shot timer raised a second interrupt");
            err_cnt++;
        end
        finish_test("one-shot timer", e0);
    endtask

    task automatic test_periodic();
        int e0;
        bit hit;
        e0 = err_cnt;
        write_csr(`CSR_TCFG, '1, {30'(PERIODIC_INIT), 2'b11});
        for (int n = 0; n < 3; n++) begin
            wait_int(INT_TIMEOUT, hit);
            if (!hit) begin
                $display("timeout waiting for periodic timer interrupt %0d", n);
                err_cnt++;
            end
            write_csr(`CSR_TICLR, '1, 32'h1);
            expect_int("has_int after ticlr", 1'b0);
        end
        write_csr(`CSR_TCFG, '1, '0);
        write_csr(`CSR_TICLR, '1, 32'h1);
        write_csr(`CSR_ECFG, '1, '0);
        finish_test("periodic timer", e0);
    endtask

    task automatic test_counter();
        int          e0;
        csr_data_t   old;
        csr_data_t   off;
        logic [63:0] c0;
        logic [63:0] c1;
        e0 = err_cnt;
        read_csr(`CSR_CNTC, old);
        off = $random(seed);
        @(negedge clk);
        c0 = counter;
        tick();
        write_csr(`CSR_CNTC, '1, off);
        repeat (CNT_GAP - 2) tick();
        @(negedge clk);
        c1 = counter;
        tick();
        check_counter("counter delta", c1 - c0,
                      64'(CNT_GAP) + {{32{off[31]}}, off} - {{32{old[31]}}, old});
        finish_test("stable counter", e0);
    endtask

    initial begin
        seed     = 32'hf79b814d;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        wr       = '0;
        raddr    = '0;
        evt      = '0;
        hw_int   = '0;
        for (int i = 0; i < 20 && rstn !== 1'b1; i++)
            @(posedge clk);
        if (rstn !== 1'b1) begin
            $display("reset was never released");
            err_cnt++;
        end
        tick();
        test_reset_access();
        test_trap();
        test_interrupts();
        test_oneshot();
        test_periodic();
        test_counter();
        err_cnt += DUT.u_trap_ctrl.u_checker.assert_errs;
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
design/csr_regs_pkg.sv
design/csr_trap_pkg.sv
design/csr_trap_ctrl.sv
design/csr_int_ctrl.sv
design/csr_timer.sv
design/csr_save_regs.sv
design/csr_read_mux.sv
design/csr_top.sv
verification/csr_tb_clkgen.sv
verification/csr_checker.sv
verification/csr_tb.sv

// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = csr_tb
FLIST  = flist.f
OBJDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
